/* bench/usb_bulk_vectors.txt */
// kind addr endp pid len first hsk (hex; kind 0 OUT 1 SOF 2 IN 4 app push 5 app drain)
// pid 0 DATA0 2 DATA1, hsk 0 ACK 2 NAK f none, drain leaves app_ready at len
0 2a 1 0 10 a1 0
0 2a 1 2 08 a2 0
0 2a 1 2 08 a3 0
0 2b 1 0 00 00 f
0 2a 2 0 00 00 f
1 2a 1 0 00 00 f
0 2a 1 0 0c a4 0
5 00 0 0 00 00 f
0 2a 1 2 30 b1 0
0 2a 1 0 30 b2 0
0 2a 1 2 30 b3 2
0 2a 1 2 30 b4 2
5 00 0 0 01 00 f
0 2a 1 2 30 b5 0
2 2a 1 0 00 00 2
4 00 0 0 20 c1 f
4 00 0 0 05 c2 f
2 2a 1 0 00 00 0
2 2b 1 0 00 00 f
2 2a 1 2 00 00 0
2 2a 1 0 00 00 2

/* verilog.f */
hw/usb_pkg.sv
hw/usb_token_filter.sv
hw/usb_credit_fifo.sv
hw/usb_bulk_transfer.sv
hw/usb_bulk_endpoint.sv
bench/usb_bulk_properties.sv
bench/usb_bulk_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run the bulk endpoint testbench from the project root
rm -f sim.log
verilator --binary --timing --assert --top-module usb_bulk_tb -f verilog.f -o usb_bulk_sim \
  && ./obj_dir/usb_bulk_sim > sim.log 2>&1 \
  || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
exit 0

/* bench/usb_bulk_tb.sv */
`default_nettype none

module usb_bulk_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int         VEC_FIELDS = 7;
  localparam int         VEC_MAX    = 40;
  localparam logic [6:0] DEV_ADDR   = 7'h2a;
  localparam int         TX_DEPTH   = 128;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  tok_valid;
  usb_pkg::token_t       tok;
  logic                  dat_pid_valid;
  usb_pkg::pid_data_e    dat_pid;
  logic                  rx_valid;
  usb_pkg::stream_beat_t rx_beat;
  logic                  rx_ready;
  logic                  hsk_valid;
  usb_pkg::pid_hsk_e     hsk;
  logic                  hsk_send;
  usb_pkg::pid_hsk_e     hsk_type;
  logic                  hsk_sent;
  logic                  dat_send;
  usb_pkg::pid_data_e    dat_type;
  logic                  tx_valid;
  usb_pkg::stream_beat_t tx_beat;
  logic                  tx_ready;
  logic                  app_push;
  usb_pkg::stream_beat_t app_beat_in;
  logic                  app_credit;
  logic                  app_valid;
  usb_pkg::stream_beat_t app_beat_out;
  logic                  app_ready;

  logic [15:0]           vec_mem [VEC_MAX * VEC_FIELDS];
  int                    n_vectors = 0;
  int                    error_count = 0;
  int                    check_count = 0;
  logic [31:0]           lfsr_state = 32'h65ed;
  usb_pkg::stream_beat_t pkt_buf[$];
  usb_pkg::stream_beat_t rx_expect[$];
  usb_pkg::stream_beat_t rx_seen[$];
  usb_pkg::stream_beat_t tx_expect[$];
  int                    rx_checked = 0;
  int                    tx_pushed = 0;
  int                    credits_returned = 0;
  usb_pkg::pid_data_e    out_toggle_model = usb_pkg::DATA0;

  usb_bulk_endpoint #(
    .ENDPOINT_NUM(4'd1),
    .RX_DEPTH    (128),
    .TX_DEPTH    (TX_DEPTH)
  ) usb_bulk_endpoint_inst (
    .clock_i        (clock),
    .reset_i        (reset),
    .usb_addr_i     (DEV_ADDR),
    .tok_valid_i    (tok_valid),
    .tok_i          (tok),
    .dat_pid_valid_i(dat_pid_valid),
    .dat_pid_i      (dat_pid),
    .rx_valid_i     (rx_valid),
    .rx_beat_i      (rx_beat),
    .rx_ready_o     (rx_ready),
    .hsk_valid_i    (hsk_valid),
    .hsk_i          (hsk),
    .hsk_send_o     (hsk_send),
    .hsk_type_o     (hsk_type),
    .hsk_sent_i     (hsk_sent),
    .dat_send_o     (dat_send),
    .dat_type_o     (dat_type),
    .tx_valid_o     (tx_valid),
    .tx_beat_o      (tx_beat),
    .tx_ready_i     (tx_ready),
    .app_push_i     (app_push),
    .app_beat_i     (app_beat_in),
    .app_credit_o   (app_credit),
    .app_valid_o    (app_valid),
    .app_beat_o     (app_beat_out),
    .app_ready_i    (app_ready)
  );

  always #4 clock = ~clock;

  // Application side monitor, sampled between edges
  always @(negedge clock) begin
    if (app_valid && app_ready) begin
      rx_seen.push_back(app_beat_out);
    end
    if (app_credit) begin
      credits_returned = credits_returned + 1;
    end
  end

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_random(input int nbits, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[6:0], lfsr_state[0]};
    end
  endtask

  function automatic string kind_name(input logic [3:0] kind);
    case (kind)
      4'h0: return "OUT";
      4'h1: return "SOF";
      4'h2: return "IN";
      4'h3: return "SETUP";
      4'h4: return "app push";
      4'h5: return "app drain";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  // First byte comes from the vector, the rest from the LFSR
  task automatic build_packet(input int len, input logic [7:0] first);
    usb_pkg::stream_beat_t beat;
    logic [7:0]            value;
    pkt_buf.delete();
    for (int i = 0; i < len; i++) begin
      if (i == 0) begin
        value = first;
      end else begin
        take_random(8, value);
      end
      beat.data = value;
      beat.last = (i == len - 1);
      pkt_buf.push_back(beat);
    end
  endtask

  task automatic send_token(input logic [1:0] kind, input logic [6:0] addr,
                            input logic [3:0] endp);
    usb_pkg::token_t t;
    t.kind = usb_pkg::pid_tok_e'(kind);
    t.addr = addr;
    t.endp = endp;
    @(posedge clock);
    tok_valid <= 1'b1;
    tok <= t;
    @(posedge clock);
    tok_valid <= 1'b0;
  endtask

  task automatic watch_silence();
    for (int i = 0; i < 12; i++) begin
      @(negedge clock);
      if (hsk_send || dat_send || tx_valid || rx_ready) begin
        report_failure("a token that should be ignored got a response");
      end
    end
  endtask

  task automatic finish_handshake();
    @(posedge clock);
    hsk_sent <= 1'b1;
    @(posedge clock);
    hsk_sent <= 1'b0;
  endtask

  task automatic out_transaction(input logic [6:0] addr, input logic [3:0] endp,
                                 input logic [1:0] pid, input int len, input logic [7:0] first,
                                 input logic [3:0] expect_hsk);
    logic store;
    build_packet(len, first);
    send_token(usb_pkg::TOK_OUT, addr, endp);
    if (expect_hsk == 4'hf) begin
      watch_silence();
    end else begin
      // Only a fresh toggle on an ACKed packet reaches the application
      store = (expect_hsk == 4'h0) && (pid == out_toggle_model);
      dat_pid_valid <= 1'b1;
      dat_pid <= usb_pkg::pid_data_e'(pid);
      @(posedge clock);
      dat_pid_valid <= 1'b0;
      foreach (pkt_buf[i]) begin
        rx_valid <= 1'b1;
        rx_beat <= pkt_buf[i];
        do begin
          @(negedge clock);
        end while (!rx_ready);
        @(posedge clock);
      end
      rx_valid <= 1'b0;
      @(negedge clock);
      check_value(32'(hsk_send), 32'(1'b1), "OUT handshake one cycle after the last byte");
      check_value(32'(hsk_type), 32'(expect_hsk), "OUT handshake type");
      finish_handshake();
      if (store) begin
        foreach (pkt_buf[i]) begin
          rx_expect.push_back(pkt_buf[i]);
        end
        out_toggle_model = (out_toggle_model == usb_pkg::DATA0) ? usb_pkg::DATA1
                                                                 : usb_pkg::DATA0;
      end
    end
  endtask

  task automatic in_transaction(input logic [6:0] addr, input logic [3:0] endp,
                                input logic [1:0] pid, input logic [3:0] expect_hsk);
    usb_pkg::stream_beat_t want;
    logic [7:0]            ready_bit;
    logic                  done;
    int                    waits;
    send_token(usb_pkg::TOK_IN, addr, endp);
    if (expect_hsk == 4'hf) begin
      watch_silence();
    end else begin
      waits = 0;
      do begin
        @(negedge clock);
        waits++;
      end while (!(hsk_send || dat_send) && waits < 16);
      // Token accepted on the edge before, match two cycles on, answer two more
      check_value(32'(waits), 32'd4, "IN answer two cycles after the matched token");
      check_value(32'(dat_send), 32'(expect_hsk == 4'h0), "IN answered with data");
      if (hsk_send) begin
        check_value(32'(hsk_type), 32'(usb_pkg::HSK_NAK), "IN handshake type");
        finish_handshake();
      end else if (dat_send) begin
        check_value(32'(dat_type), 32'(pid), "IN data PID");
        done = 1'b0;
        // Random stalls from the encoder side
        while (!done) begin
          @(posedge clock);
          take_random(1, ready_bit);
          tx_ready <= ready_bit[0];
          @(negedge clock);
          if (tx_valid && tx_ready) begin
            if (tx_expect.size() == 0) begin
              report_failure("an IN byte was sent while none was pending");
              done = 1'b1;
            end else begin
              want = tx_expect.pop_front();
              check_value(32'(tx_beat.data), 32'(want.data), "IN byte");
              check_value(32'(tx_beat.last), 32'(want.last), "IN last flag");
              done = tx_beat.last;
            end
          end
        end
        @(posedge clock);
        tx_ready <= 1'b0;
        hsk_valid <= 1'b1;
        hsk <= usb_pkg::HSK_ACK;
        @(posedge clock);
        hsk_valid <= 1'b0;
      end
    end
  endtask

  task automatic push_packet(input int len, input logic [7:0] first);
    build_packet(len, first);
    foreach (pkt_buf[i]) begin
      @(posedge clock);
      // The application spends one credit per beat
      while (TX_DEPTH - tx_pushed + credits_returned == 0) begin
        app_push <= 1'b0;
        @(posedge clock);
      end
      app_push <= 1'b1;
      app_beat_in <= pkt_buf[i];
      tx_pushed++;
      tx_expect.push_back(pkt_buf[i]);
    end
    @(posedge clock);
    app_push <= 1'b0;
  endtask

  task automatic compare_delivered();
    usb_pkg::stream_beat_t want;
    while (rx_checked < rx_seen.size()) begin
      if (rx_checked >= rx_expect.size()) begin
        report_failure("the application received a byte that no accepted packet carried");
      end else begin
        want = rx_expect[rx_checked];
        check_value(32'(rx_seen[rx_checked].data), 32'(want.data), "OUT byte at application");
        check_value(32'(rx_seen[rx_checked].last), 32'(want.last), "OUT last at application");
      end
      rx_checked++;
    end
  endtask

  // Empty the receive buffer, then leave app_ready at the given level
  task automatic drain_rx(input logic level);
    @(posedge clock);
    app_ready <= 1'b1;
    while (rx_seen.size() < rx_expect.size()) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
    compare_delivered();
    app_ready <= level;
  endtask

  initial begin
    int          base;
    int          count;
    int          errors_before;
    logic [3:0]  kind;
    logic [6:0]  addr;
    logic [3:0]  endp;
    logic [1:0]  pid;
    int          len;
    logic [7:0]  first;
    logic [3:0]  expect_hsk;
    tok_valid <= 1'b0;
    tok <= '0;
    dat_pid_valid <= 1'b0;
    dat_pid <= usb_pkg::DATA0;
    rx_valid <= 1'b0;
    rx_beat <= '0;
    hsk_valid <= 1'b0;
    hsk <= usb_pkg::HSK_ACK;
    hsk_sent <= 1'b0;
    tx_ready <= 1'b0;
    app_push <= 1'b0;
    app_beat_in <= '0;
    app_ready <= 1'b1;
    reset <= 1'b1;
    for (int i = 0; i < VEC_MAX * VEC_FIELDS; i++) begin
      vec_mem[i] = 16'hffff;
    end
    $readmemh("bench/usb_bulk_vectors.txt", vec_mem);
    count = 0;
    while (count < VEC_MAX && vec_mem[count * VEC_FIELDS] != 16'hffff) begin
      count++;
    end
    n_vectors = count;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_value(32'(hsk_send || dat_send || tx_valid), 32'(1'b0), "encoder outputs after reset");
    check_value(32'(app_valid || app_credit), 32'(1'b0), "application outputs after reset");
    $display("test 0 reset: %s", (error_count == 0) ? "ok" : "errors");
    repeat (2) @(posedge clock);
    for (int t = 0; t < n_vectors; t++) begin
      base = t * VEC_FIELDS;
      kind = vec_mem[base][3:0];
      addr = vec_mem[base + 1][6:0];
      endp = vec_mem[base + 2][3:0];
      pid = vec_mem[base + 3][1:0];
      len = int'(vec_mem[base + 4]);
      first = vec_mem[base + 5][7:0];
      expect_hsk = vec_mem[base + 6][3:0];
      errors_before = error_count;
      case (kind)
        4'h0: out_transaction(addr, endp, pid, len, first, expect_hsk);
        4'h2: in_transaction(addr, endp, pid, expect_hsk);
        4'h1, 4'h3: begin
          send_token(kind[1:0], addr, endp);
          watch_silence();
        end
        4'h4: push_packet(len, first);
        4'h5: drain_rx(len[0]);
        default: report_failure("the vector file holds an unknown transaction kind");
      endcase
      $display("test %0d %s: %s", t + 1, kind_name(kind),
               (error_count == errors_before) ? "ok" : "errors");
    end
    drain_rx(1'b1);
    repeat (10) @(posedge clock);
    compare_delivered();
    check_value(32'(rx_seen.size()), 32'(rx_expect.size()), "bytes delivered versus accepted");
    check_value(32'(tx_expect.size()), 32'd0, "IN bytes left unsent");
    check_value(32'(credits_returned), 32'(tx_pushed), "transmit credits returned");
    $display("%0d tests, %0d checks, %0d errors", n_vectors, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog scaled by the number of transactions
  initial begin
    wait (n_vectors > 0);
    #(n_vectors * 2000);
    $display("timeout: the run did not finish within %0d ns", n_vectors * 2000);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/usb_bulk_properties.sv */
`default_nettype none

module usb_bulk_properties #(
  parameter int CREDIT_W = 8
) (
  input wire logic                  clock_i,
  input wire logic                  reset_i,
  input wire logic                  hsk_send_i,
  input wire logic                  dat_send_i,
  input wire logic                  tx_valid_i,
  input wire logic                  tx_ready_i,
  input wire usb_pkg::stream_beat_t tx_beat_i,
  input wire logic                  rx_push_i,
  input wire logic [CREDIT_W-1:0]   rx_credits_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // The encoder takes one packet request at a time
  send_exclusive: assert property (@(posedge clock_i) disable iff (reset_i)
    !(hsk_send_i && dat_send_i))
    else $error("handshake and data packet requested in the same cycle");

  tx_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    (tx_valid_i && !tx_ready_i) |=> (tx_valid_i && $stable(tx_beat_i)))
    else $error("tx beat changed while the encoder stalled");

  // Receive buffer space must be reserved before a byte is stored
  push_credit: assert property (@(posedge clock_i) disable iff (reset_i)
    !(rx_push_i && (rx_credits_i == '0)))
    else $error("receive byte stored with no credit left");

endmodule

bind usb_bulk_transfer usb_bulk_properties #(
  .CREDIT_W(CW)
) usb_bulk_properties_inst (
  .clock_i     (clock_i),
  .reset_i     (reset_i),
  .hsk_send_i  (hsk_send_o),
  .dat_send_i  (dat_send_o),
  .tx_valid_i  (tx_valid_o),
  .tx_ready_i  (tx_ready_i),
  .tx_beat_i   (tx_beat_o),
  .rx_push_i   (rx_push_o),
  .rx_credits_i(rx_credits)
);

`default_nettype wire

/* hw/usb_bulk_endpoint.sv */
`default_nettype none

module usb_bulk_endpoint #(
  parameter logic [3:0] ENDPOINT_NUM = 4'd1,
  parameter int         RX_DEPTH     = 128,
  parameter int         TX_DEPTH     = 128
) (
  input  wire logic                  clock_i,
  input  wire logic                  reset_i,
  input  wire logic [6:0]            usb_addr_i,
  // Decoder side
  input  wire logic                  tok_valid_i,
  input  wire usb_pkg::token_t       tok_i,
  input  wire logic                  dat_pid_valid_i,
  input  wire usb_pkg::pid_data_e    dat_pid_i,
  input  wire logic                  rx_valid_i,
  input  wire usb_pkg::stream_beat_t rx_beat_i,
  output      logic                  rx_ready_o,
  input  wire logic                  hsk_valid_i,
  input  wire usb_pkg::pid_hsk_e     hsk_i,
  // Encoder side
  output      logic                  hsk_send_o,
  output      usb_pkg::pid_hsk_e     hsk_type_o,
  input  wire logic                  hsk_sent_i,
  output      logic                  dat_send_o,
  output      usb_pkg::pid_data_e    dat_type_o,
  output      logic                  tx_valid_o,
  output      usb_pkg::stream_beat_t tx_beat_o,
  input  wire logic                  tx_ready_i,
  // Application side
  input  wire logic                  app_push_i,
  input  wire usb_pkg::stream_beat_t app_beat_i,
  output      logic                  app_credit_o,
  output      logic                  app_valid_o,
  output      usb_pkg::stream_beat_t app_beat_o,
  input  wire logic                  app_ready_i
);

  logic                  match_valid;
  usb_pkg::pid_tok_e     match_kind;
  logic                  rx_push;
  usb_pkg::stream_beat_t rx_push_beat;
  logic                  rx_credit;
  logic                  tx_pkt_ready;
  usb_pkg::stream_beat_t fifo_beat;
  logic                  fifo_pop;

  usb_token_filter #(
    .ENDPOINT_NUM(ENDPOINT_NUM)
  ) usb_token_filter_inst (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .usb_addr_i   (usb_addr_i),
    .tok_valid_i  (tok_valid_i),
    .tok_i        (tok_i),
    .match_valid_o(match_valid),
    .match_kind_o (match_kind)
  );

  usb_bulk_transfer #(
    .RX_DEPTH(RX_DEPTH)
  ) usb_bulk_transfer_inst (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .match_valid_i  (match_valid),
    .match_kind_i   (match_kind),
    .dat_pid_valid_i(dat_pid_valid_i),
    .dat_pid_i      (dat_pid_i),
    .rx_valid_i     (rx_valid_i),
    .rx_beat_i      (rx_beat_i),
    .hsk_sent_i     (hsk_sent_i),
    .hsk_valid_i    (hsk_valid_i),
    .hsk_i          (hsk_i),
    .tx_ready_i     (tx_ready_i),
    .rx_credit_i    (rx_credit),
    .tx_pkt_ready_i (tx_pkt_ready),
    .fifo_beat_i    (fifo_beat),
    .rx_ready_o     (rx_ready_o),
    .hsk_send_o     (hsk_send_o),
    .hsk_type_o     (hsk_type_o),
    .dat_send_o     (dat_send_o),
    .dat_type_o     (dat_type_o),
    .tx_valid_o     (tx_valid_o),
    .tx_beat_o      (tx_beat_o),
    .rx_push_o      (rx_push),
    .rx_push_beat_o (rx_push_beat),
    .fifo_pop_o     (fifo_pop)
  );

  // Host to application, credits return to the FSM
  usb_credit_fifo #(
    .payload_t(usb_pkg::stream_beat_t),
    .DEPTH    (RX_DEPTH)
  ) rx_fifo (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .push_i     (rx_push),
    .push_data_i(rx_push_beat),
    .pop_ready_i(app_ready_i),
    .pop_valid_o(app_valid_o),
    .pop_data_o (app_beat_o),
    .credit_o   (rx_credit),
    .pkt_ready_o()
  );

  // Application to host, credits return to the application
  usb_credit_fifo #(
    .payload_t(usb_pkg::stream_beat_t),
    .DEPTH    (TX_DEPTH)
  ) tx_fifo (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .push_i     (app_push_i),
    .push_data_i(app_beat_i),
    .pop_ready_i(fifo_pop),
    .pop_valid_o(),
    .pop_data_o (fifo_beat),
    .credit_o   (app_credit_o),
    .pkt_ready_o(tx_pkt_ready)
  );

endmodule

`default_nettype wire

/* hw/usb_bulk_transfer.sv */
`default_nettype none

module usb_bulk_transfer #(
  parameter int RX_DEPTH = 128
) (
  input  wire logic                  clock_i,
  input  wire logic                  reset_i,
  input  wire logic                  match_valid_i,
  input  wire usb_pkg::pid_tok_e     match_kind_i,
  input  wire logic                  dat_pid_valid_i,
  input  wire usb_pkg::pid_data_e    dat_pid_i,
  input  wire logic                  rx_valid_i,
  input  wire usb_pkg::stream_beat_t rx_beat_i,
  input  wire logic                  hsk_sent_i,
  input  wire logic                  hsk_valid_i,
  input  wire usb_pkg::pid_hsk_e     hsk_i,
  input  wire logic                  tx_ready_i,
  input  wire logic                  rx_credit_i,
  input  wire logic                  tx_pkt_ready_i,
  input  wire usb_pkg::stream_beat_t fifo_beat_i,
  output      logic                  rx_ready_o,
  output      logic                  hsk_send_o,
  output      usb_pkg::pid_hsk_e     hsk_type_o,
  output      logic                  dat_send_o,
  output      usb_pkg::pid_data_e    dat_type_o,
  output      logic                  tx_valid_o,
  output      usb_pkg::stream_beat_t tx_beat_o,
  output      logic                  rx_push_o,
  output      usb_pkg::stream_beat_t rx_push_beat_o,
  output      logic                  fifo_pop_o
);

  localparam int CW = $clog2(RX_DEPTH + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DATI_TX,
    ST_DATI_ACK,
    ST_DATO_RX,
    ST_DATO_HSK
  } state_e;

  state_e             state;
  logic               in_start_q;
  usb_pkg::pid_data_e out_toggle;
  usb_pkg::pid_data_e in_toggle;
  logic               rx_write_q;
  usb_pkg::pid_hsk_e  rx_hsk_q;
  logic [CW-1:0]      rx_credits;
  logic               credits_ok;
  logic               rx_fire;

  function automatic usb_pkg::pid_data_e next_toggle(input usb_pkg::pid_data_e t);
    return (t == usb_pkg::DATA0) ? usb_pkg::DATA1 : usb_pkg::DATA0;
  endfunction

  assign rx_ready_o = (state == ST_DATO_RX);
  assign rx_fire = rx_valid_i && rx_ready_o;
  // Bytes of NAKed or duplicate packets are consumed but never stored
  assign rx_push_o = rx_fire && rx_write_q;
  assign rx_push_beat_o = rx_beat_i;

  // Bytes follow the cycle after the DATA PID request
  assign tx_valid_o = (state == ST_DATI_TX) && !dat_send_o;
  assign tx_beat_o = fifo_beat_i;
  assign fifo_pop_o = tx_valid_o && tx_ready_i;

  assign credits_ok = (rx_credits >= CW'(usb_pkg::MAX_PACKET_BYTES));

  // Receive buffer space, one credit per stored byte
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      rx_credits <= CW'(RX_DEPTH);
    end else if (rx_credit_i && !rx_push_o) begin
      rx_credits <= rx_credits + 1'b1;
    end else if (!rx_credit_i && rx_push_o) begin
      rx_credits <= rx_credits - 1'b1;
    end
  end

  // Decide the fate of an OUT packet when its DATA PID shows up
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      rx_write_q <= 1'b0;
      rx_hsk_q   <= usb_pkg::HSK_ACK;
    end else if (dat_pid_valid_i) begin
      rx_write_q <= credits_ok && (dat_pid_i == out_toggle);
      rx_hsk_q   <= credits_ok ? usb_pkg::HSK_ACK : usb_pkg::HSK_NAK;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state      <= ST_IDLE;
      in_start_q <= 1'b0;
      hsk_send_o <= 1'b0;
      hsk_type_o <= usb_pkg::HSK_ACK;
      dat_send_o <= 1'b0;
      dat_type_o <= usb_pkg::DATA0;
      out_toggle <= usb_pkg::DATA0;
      in_toggle  <= usb_pkg::DATA0;
    end else begin
      hsk_send_o <= 1'b0;
      dat_send_o <= 1'b0;
      in_start_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          // IN answer goes out two cycles after the matched token
          if (in_start_q) begin
            if (tx_pkt_ready_i) begin
              dat_send_o <= 1'b1;
              dat_type_o <= in_toggle;
              state      <= ST_DATI_TX;
            end else begin
              hsk_send_o <= 1'b1;
              hsk_type_o <= usb_pkg::HSK_NAK;
              state      <= ST_DATO_HSK;
            end
          end else if (match_valid_i) begin
            if (match_kind_i == usb_pkg::TOK_IN) begin
              in_start_q <= 1'b1;
            end else if (match_kind_i == usb_pkg::TOK_OUT) begin
              state <= ST_DATO_RX;
            end
          end
        end
        ST_DATO_RX: begin
          if (rx_fire && rx_beat_i.last) begin
            hsk_send_o <= 1'b1;
            hsk_type_o <= rx_hsk_q;
            if (rx_write_q) begin
              out_toggle <= next_toggle(out_toggle);
            end
            state <= ST_DATO_HSK;
          end
        end
        // Also used while an IN NAK is being sent
        ST_DATO_HSK: begin
          if (hsk_sent_i) begin
            state <= ST_IDLE;
          end
        end
        ST_DATI_TX: begin
          if (fifo_pop_o && fifo_beat_i.last) begin
            state <= ST_DATI_ACK;
          end
        end
        ST_DATI_ACK: begin
          if (hsk_valid_i) begin
            if (hsk_i == usb_pkg::HSK_ACK) begin
              in_toggle <= next_toggle(in_toggle);
            end
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/usb_credit_fifo.sv */
`default_nettype none

module usb_credit_fifo #(
  parameter type payload_t = usb_pkg::stream_beat_t,
  parameter int  DEPTH     = 128
) (
  input  wire logic     clock_i,
  input  wire logic     reset_i,
  input  wire logic     push_i,
  input  wire payload_t push_data_i,
  input  wire logic     pop_ready_i,
  output      logic     pop_valid_o,
  output      payload_t pop_data_o,
  output      logic     credit_o,
  output      logic     pkt_ready_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic [CW-1:0]   pkt_count;
  logic            do_push;
  logic            do_pop;

  // The writer holds credits, so a push into a full buffer is a protocol error
  assign do_push = push_i && (count != CW'(DEPTH));
  assign do_pop = pop_valid_o && pop_ready_i;

  assign pop_valid_o = (count != '0);
  assign pop_data_o = mem[rd_ptr];
  assign pkt_ready_o = (pkt_count != '0);

  always_ff @(posedge clock_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pkt_count <= '0;
      credit_o  <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(do_push) - CW'(do_pop);
      // Complete packets stored, counted by their last beats
      pkt_count <= pkt_count + CW'(do_push && push_data_i.last)
                             - CW'(do_pop && pop_data_o.last);
      // One credit back to the writer per beat that leaves
      credit_o <= do_pop;
    end
  end

endmodule

`default_nettype wire

/* hw/usb_token_filter.sv */
`default_nettype none

module usb_token_filter #(
  parameter logic [3:0] ENDPOINT_NUM = 4'd1
) (
  input  wire logic                clock_i,
  input  wire logic                reset_i,
  input  wire logic [6:0]          usb_addr_i,
  input  wire logic                tok_valid_i,
  input  wire usb_pkg::token_t     tok_i,
  output      logic                match_valid_o,
  output      usb_pkg::pid_tok_e   match_kind_o
);

  logic            tok_valid_q;
  usb_pkg::token_t tok_q;
  logic            kind_ok;
  logic            target_ok;

  // First stage, capture the token as the decoder presents it
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      tok_valid_q <= 1'b0;
    end else begin
      tok_valid_q <= tok_valid_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (tok_valid_i) begin
      tok_q <= tok_i;
    end
  end

  // SOF and SETUP never reach the bulk FSM
  assign kind_ok = (tok_q.kind == usb_pkg::TOK_OUT) || (tok_q.kind == usb_pkg::TOK_IN);
  assign target_ok = (tok_q.addr == usb_addr_i) && (tok_q.endp == ENDPOINT_NUM);

  // Second stage, one pulse per matching token
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      match_valid_o <= 1'b0;
      match_kind_o  <= usb_pkg::TOK_OUT;
    end else begin
      match_valid_o <= tok_valid_q && kind_ok && target_ok;
      if (tok_valid_q) begin
        match_kind_o <= tok_q.kind;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/usb_pkg.sv */
`default_nettype none

package usb_pkg;

  // Token PIDs as reduced by the decoder to two bits
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } pid_tok_e;

  // Handshake PIDs, STALL and NYET are not used by this endpoint
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } pid_hsk_e;

  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } pid_data_e;

  // Decoded token fields
  typedef struct packed {
    pid_tok_e   kind;
    logic [6:0] addr;
    logic [3:0] endp;
  } token_t;

  // One byte of a packet, last marks the final byte
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_beat_t;

  // Largest full-speed bulk payload
  localparam int MAX_PACKET_BYTES = 64;

endpackage

`default_nettype wire
